//--- rtl/expired_victim_finder.sv
/* expired victim finder
   first expired line at or after a rotating start, plus expiry counts */
module expired_victim_finder #(
	parameter int N_LINES = 8
) (
	input  lease_pkg::lease_t          leases_i [N_LINES],
	input  logic [$clog2(N_LINES)-1:0] rotate_i,         // search start line
	output logic [$clog2(N_LINES)-1:0] victim_o,         // valid with any_expired_o
	output logic                       any_expired_o,
	output logic                       multi_expired_o   // two or more expired
);

	localparam int BW_IDX = $clog2(N_LINES);

	logic [N_LINES-1:0]   expired;     // one flag per line
	logic [2*N_LINES-1:0] doubled;
	logic [N_LINES-1:0]   rotated;
	logic [BW_IDX-1:0]    first_idx;   // index in rotated order

	// lease of zero means expired
	always_comb begin
		for (int i = 0; i < N_LINES; i++) begin
			expired[i] = (leases_i[i] == '0);
		end
	end

	// rotation
	// ----------------------------------------------------------------------
	// bit k of rotated is line (k + rotate_i) mod N_LINES
	assign doubled = {expired, expired} >> rotate_i;
	assign rotated = doubled[N_LINES-1:0];

	// priority encode, lowest set bit
	always_comb begin
		first_idx = '0;
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (rotated[i]) begin
				first_idx = BW_IDX'(i);
			end
		end
	end

	// undo the rotation, wraps since N_LINES is a power of two
	assign victim_o = first_idx + rotate_i;

	assign any_expired_o   = |expired;
	assign multi_expired_o = |(expired & (expired - 1'b1));   // clear lowest, anything left

endmodule

//--- rtl/lease_cache_policy_top.sv
/* lease cache policy top
   joins the lease lookup table to the policy controller */
`include "lease_settings.svh"

module lease_cache_policy_top #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                                    clock_i,
	input  logic                                    resetn_i,
	// software write bus
	input  logic                                    con_wren_i,
	input  logic                                    llt_wren_i,
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0]   llt_addr_i,
	input  logic [31:0]                             llt_data_i,
	// cache controller side
	input  logic [`LEASE_REF_ADDR_BW-1:0]           llt_search_addr_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cache_addr_i,
	input  logic                                    hit_i,
	input  logic                                    miss_i,
	output logic                                    done_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] addr_o,
	output logic                                    swap_o,
	output logic                                    expired_o,
	output logic                                    expired_multi_o,
	output logic                                    default_o
);

	lease_lookup_if lookup ();   // search and result

	lease_lookup_table u_table (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.llt_wren_i (llt_wren_i),
		.llt_addr_i (llt_addr_i),
		.llt_data_i (llt_data_i),
		.lookup     (lookup)
	);

	lease_policy_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_controller (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.con_wren_i      (con_wren_i),
		.cfg_addr_i      (llt_addr_i),   // config shares the table bus
		.cfg_data_i      (llt_data_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.cache_addr_i    (cache_addr_i),
		.search_addr_i   (llt_search_addr_i),
		.lookup          (lookup),
		.done_o          (done_o),
		.addr_o          (addr_o),
		.swap_o          (swap_o),
		.expired_o       (expired_o),
		.expired_multi_o (expired_multi_o),
		.default_o       (default_o)
	);

endmodule

//--- rtl/lease_lfsr.sv
/* 9-bit galois lfsr, polynomial x^9 + x^5 + 1
   maximal length, steps once per cycle with enable_i */
module lease_lfsr (
	input  logic       clock_i,
	input  logic       resetn_i,
	input  logic [8:0] seed_i,     // loaded in reset, must be non-zero
	input  logic       enable_i,   // step one position
	output logic [8:0] value_o
);

	localparam logic [8:0] TAP_MASK = 9'h110;   // taps 9 and 5

	logic [8:0] state_q;
	logic [8:0] state_next;

	// shift right, fold the output bit back into the taps
	assign state_next = {1'b0, state_q[8:1]} ^ (state_q[0] ? TAP_MASK : 9'h000);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= seed_i;
		end else if (enable_i) begin
			state_q <= state_next;
		end
	end

	assign value_o = state_q;

endmodule

//--- rtl/lease_lookup_if.sv
/* lease lookup interface
   one combinational table search and its result */
`include "lease_settings.svh"

interface lease_lookup_if;

	logic [`LEASE_REF_ADDR_BW-1:0] search_addr;   // ref instruction word addr
	logic                          hit;           // search matched a valid entry
	lease_pkg::lease_t             lease0;
	lease_pkg::lease_t             lease1;
	logic [`LEASE_PROB_BW-1:0]     prob;          // chance of lease0

	// table side answers in the same cycle
	modport tbl (input search_addr, output hit, lease0, lease1, prob);

	// controller side samples with its strobe
	modport policy (output search_addr, input hit, lease0, lease1, prob);

endinterface

//--- rtl/lease_lookup_table.sv
/* lease lookup table
   maps reference word addresses to a lease pair and a lease0 probability */
`include "lease_settings.svh"

module lease_lookup_table (
	input  logic                                  clock_i,
	input  logic                                  resetn_i,
	input  logic                                  llt_wren_i,  // software write strobe
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0] llt_addr_i,  // field on top two bits
	input  logic [31:0]                           llt_data_i,
	lease_lookup_if.tbl                           lookup
);

	localparam int ENTRY_BW = $clog2(`LEASE_LLT_ENTRIES);

	logic [`LEASE_LLT_ENTRIES-1:0] valid_q;                          // one per entry
	logic [`LEASE_REF_ADDR_BW-1:0] ref_addr_q [`LEASE_LLT_ENTRIES];
	lease_pkg::lease_t             lease0_q   [`LEASE_LLT_ENTRIES];
	lease_pkg::lease_t             lease1_q   [`LEASE_LLT_ENTRIES];
	logic [`LEASE_PROB_BW-1:0]     prob_q     [`LEASE_LLT_ENTRIES];

	lease_pkg::llt_field_e         wr_field;
	logic [ENTRY_BW-1:0]           wr_entry;

	logic                          hit_c;
	lease_pkg::lease_t             lease0_c;
	lease_pkg::lease_t             lease1_c;
	logic [`LEASE_PROB_BW-1:0]     prob_c;

	assign wr_field = lease_pkg::llt_field_e'(llt_addr_i[ENTRY_BW+1 -: 2]);
	assign wr_entry = llt_addr_i[ENTRY_BW-1:0];

	// write port
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (llt_wren_i && (wr_field == lease_pkg::FIELD_REF_ADDR)) begin
			valid_q[wr_entry] <= 1'b1;   // entry live once its address is known
		end
	end

	always_ff @(posedge clock_i) begin
		if (llt_wren_i) begin
			case (wr_field)
				lease_pkg::FIELD_REF_ADDR: ref_addr_q[wr_entry] <= llt_data_i[`LEASE_REF_ADDR_BW-1:0];
				lease_pkg::FIELD_LEASE0:   lease0_q[wr_entry]   <= llt_data_i[`LEASE_VALUE_BW-1:0];
				lease_pkg::FIELD_LEASE1:   lease1_q[wr_entry]   <= llt_data_i[`LEASE_VALUE_BW-1:0];
				lease_pkg::FIELD_PROB:     prob_q[wr_entry]     <= llt_data_i[`LEASE_PROB_BW-1:0];
				default:                   ;
			endcase
		end
	end

	// parallel search
	// ----------------------------------------------------------------------
	always_comb begin
		hit_c    = 1'b0;
		lease0_c = '0;   // fields read zero on a miss
		lease1_c = '0;
		prob_c   = '0;
		for (int i = 0; i < `LEASE_LLT_ENTRIES; i++) begin
			// first match wins
			if (!hit_c && valid_q[i] && (ref_addr_q[i] == lookup.search_addr)) begin
				hit_c    = 1'b1;
				lease0_c = lease0_q[i];
				lease1_c = lease1_q[i];
				prob_c   = prob_q[i];
			end
		end
	end

	assign lookup.hit    = hit_c;
	assign lookup.lease0 = lease0_c;
	assign lookup.lease1 = lease1_c;
	assign lookup.prob   = prob_c;

endmodule

//--- rtl/lease_pkg.sv
/* lease policy package
   lease type, controller states and table field codes */
`include "lease_settings.svh"

package lease_pkg;

	// one lease counter value
	typedef logic [`LEASE_VALUE_BW-1:0] lease_t;

	// controller sequence
	typedef enum logic {
		ST_NORMAL,            // waiting for hit or miss
		ST_GEN_REPLACEMENT    // building the victim address
	} policy_state_e;

	// field select, top two bits of the table write address
	typedef enum logic [1:0] {
		FIELD_REF_ADDR = 2'd0,   // also marks the entry valid
		FIELD_LEASE0   = 2'd1,
		FIELD_LEASE1   = 2'd2,
		FIELD_PROB     = 2'd3    // probability of lease0
	} llt_field_e;

endpackage

//--- rtl/lease_policy_controller.sv
/* lease policy controller
   renews and counts down line leases, then bypasses or picks a victim on a miss */
`include "lease_settings.svh"

module lease_policy_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  logic                                    clock_i,
	input  logic                                    resetn_i,
	// config write, shares the table address bus
	input  logic                                    con_wren_i,
	input  logic [$clog2(`LEASE_LLT_ENTRIES)+1:0]   cfg_addr_i,
	input  logic [31:0]                             cfg_data_i,
	// cache controller strobes
	input  logic                                    hit_i,
	input  logic                                    miss_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cache_addr_i,   // line being referenced
	input  logic [`LEASE_REF_ADDR_BW-1:0]           search_addr_i,  // ref instr word addr
	lease_lookup_if.policy                          lookup,
	// replacement result
	output logic                                    done_o,           // one cycle pulse
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] addr_o,           // victim line
	output logic                                    swap_o,           // allocate, not bypass
	output logic                                    expired_o,        // victim had expired
	output logic                                    expired_multi_o,
	output logic                                    default_o         // default lease used
);

	localparam int BW_CAP = $clog2(CACHE_BLOCK_CAPACITY);

	lease_pkg::policy_state_e state_q;
	lease_pkg::lease_t        lease_q   [CACHE_BLOCK_CAPACITY];   // one per line
	lease_pkg::lease_t        lease_dec [CACHE_BLOCK_CAPACITY];   // all counted down
	lease_pkg::lease_t        default_lease_q;
	lease_pkg::lease_t        saved_lease_q;    // lease for the follow-up hit
	logic                     miss_followup_q;
	logic                     miss_default_q;   // pending miss took the default
	logic [BW_CAP-1:0]        cold_cnt_q;
	logic                     full_q;           // every line filled once
	logic [BW_CAP-1:0]        rotate_q;

	logic                     strobe_ok;
	lease_pkg::lease_t        prob_lease;
	lease_pkg::lease_t        sel_lease;
	logic [BW_CAP-1:0]        exp_victim;
	logic                     exp_any;
	logic                     exp_multi;
	logic                     rand_step;
	logic [8:0]               rand_val;

	assign lookup.search_addr = search_addr_i;

	assign strobe_ok = (state_q == lease_pkg::ST_NORMAL) && (hit_i || miss_i);
	assign sel_lease = lookup.hit ? prob_lease : default_lease_q;   // no match, default
	assign rand_step = (state_q == lease_pkg::ST_GEN_REPLACEMENT) && full_q && !exp_any;

	// saturating countdown of every line
	always_comb begin
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			lease_dec[i] = (lease_q[i] == '0) ? '0 : lease_q[i] - 1'b1;
		end
	end

	// submodules
	// ----------------------------------------------------------------------
	lease_prob_select u_prob_select (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.advance_i (strobe_ok),
		.lease0_i  (lookup.lease0),
		.lease1_i  (lookup.lease1),
		.prob_i    (lookup.prob),
		.lease_o   (prob_lease)
	);

	expired_victim_finder #(
		.N_LINES (CACHE_BLOCK_CAPACITY)
	) u_victim_finder (
		.leases_i        (lease_q),
		.rotate_i        (rotate_q),
		.victim_o        (exp_victim),
		.any_expired_o   (exp_any),
		.multi_expired_o (exp_multi)
	);

	lease_lfsr u_rand_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.seed_i   (9'h155),
		.enable_i (rand_step),    // only when a random victim is taken
		.value_o  (rand_val)
	);

	// default lease, config address zero
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && (cfg_addr_i == '0)) begin
			default_lease_q <= cfg_data_i[`LEASE_VALUE_BW-1:0];
		end
	end

	always_ff @(posedge clock_i) begin
		if (strobe_ok && miss_i) begin
			saved_lease_q <= sel_lease;
		end
	end

	// sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= lease_pkg::ST_NORMAL;
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
				lease_q[i] <= '0;
			end
			miss_followup_q <= 1'b0;
			miss_default_q  <= 1'b0;
			cold_cnt_q      <= '0;
			full_q          <= 1'b0;
			rotate_q        <= '0;
			done_o          <= 1'b0;
			addr_o          <= '0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
		end else begin
			done_o          <= 1'b0;   // status outputs are pulses
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;

			case (state_q)
				lease_pkg::ST_NORMAL: begin
					if (hit_i) begin
						if (miss_followup_q) begin
							// install after a miss, countdown already done
							miss_followup_q       <= 1'b0;
							lease_q[cache_addr_i] <= saved_lease_q;
						end else begin
							lease_q               <= lease_dec;
							lease_q[cache_addr_i] <= sel_lease;   // renew referenced line
							default_o             <= !lookup.hit;
						end
					end else if (miss_i) begin
						lease_q <= lease_dec;
						if (sel_lease != '0) begin
							state_q         <= lease_pkg::ST_GEN_REPLACEMENT;
							miss_followup_q <= 1'b1;
							miss_default_q  <= !lookup.hit;
						end else begin
							done_o    <= 1'b1;   // bypass, swap_o stays low
							default_o <= !lookup.hit;
						end
					end
				end

				lease_pkg::ST_GEN_REPLACEMENT: begin
					state_q   <= lease_pkg::ST_NORMAL;
					done_o    <= 1'b1;
					swap_o    <= 1'b1;
					default_o <= miss_default_q;
					if (!full_q) begin
						addr_o     <= cold_cnt_q;   // cold start fill in order
						cold_cnt_q <= cold_cnt_q + 1'b1;
						if (cold_cnt_q == {BW_CAP{1'b1}}) begin
							full_q <= 1'b1;
						end
					end else if (exp_any) begin
						addr_o          <= exp_victim;
						rotate_q        <= exp_victim + 1'b1;   // next search starts past it
						expired_o       <= 1'b1;
						expired_multi_o <= exp_multi;
					end else begin
						addr_o <= rand_val[BW_CAP-1:0];   // nothing expired, random line
					end
				end

				default: state_q <= lease_pkg::ST_NORMAL;
			endcase
		end
	end

endmodule

//--- rtl/lease_prob_select.sv
/* lease probability select
   picks lease0 or lease1 from a pseudo-random draw against the entry probability */
`include "lease_settings.svh"

module lease_prob_select (
	input  logic                      clock_i,
	input  logic                      resetn_i,
	input  logic                      advance_i,   // strobe accepted, next draw
	input  lease_pkg::lease_t         lease0_i,    // preferred lease
	input  lease_pkg::lease_t         lease1_i,
	input  logic [`LEASE_PROB_BW-1:0] prob_i,      // chance of lease0 out of 256
	output lease_pkg::lease_t         lease_o
);

	logic [8:0]                draw;
	logic [`LEASE_PROB_BW-1:0] draw_ext;

	lease_lfsr u_draw_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.seed_i   (9'h0b3),     // differs from the victim lfsr
		.enable_i (advance_i),
		.value_o  (draw)
	);

	// low byte only, so 256 always selects lease0 and 0 never does
	assign draw_ext = `LEASE_PROB_BW'(draw[7:0]);

	assign lease_o = (draw_ext < prob_i) ? lease0_i : lease1_i;

endmodule

//--- rtl/lease_settings.svh
/* lease policy settings
   table size and field widths shared by the lease policy blocks */
`ifndef LEASE_SETTINGS_SVH
`define LEASE_SETTINGS_SVH

// lease lookup table
// ----------------------------------------------------------------------
`define LEASE_LLT_ENTRIES 8   // entries in the table, power of two

// field widths
// ----------------------------------------------------------------------
`define LEASE_VALUE_BW 8   // one lease value

// word address of the referencing ld/st
`define LEASE_REF_ADDR_BW 16

// lease0 probability, 256 and up means lease0 always
`define LEASE_PROB_BW 9

`endif

//--- src.f
+incdir+rtl
rtl/lease_pkg.sv
rtl/lease_lookup_if.sv
rtl/lease_lookup_table.sv
rtl/lease_lfsr.sv
rtl/lease_prob_select.sv
rtl/expired_victim_finder.sv
rtl/lease_policy_controller.sv
rtl/lease_cache_policy_top.sv
verif/lease_policy_asserts.sv
verif/lease_policy_checker.sv
verif/lease_policy_tb.sv

//--- verif/lease_policy_asserts.sv
/* lease policy assertions
   strobe protocol checks bound into the policy controller */
module lease_policy_asserts (
	input logic                     clock_i,
	input logic                     resetn_i,
	input logic                     hit_i,
	input logic                     miss_i,
	input logic                     done_o,
	input lease_pkg::policy_state_e state_q
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;   // assertion failure count

	// done_o is a one cycle pulse
	done_pulse: assert property (@(posedge clock_i) disable iff (!resetn_i) done_o |=> !done_o)
		else begin failures++; $error("done_o high for two cycles in a row"); end

	// hit and miss are mutually exclusive
	strobe_excl: assert property (@(posedge clock_i) disable iff (!resetn_i) !(hit_i && miss_i))
		else begin failures++; $error("hit_i and miss_i high together"); end

	// no strobe while a replacement is pending
	no_strobe_busy: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(state_q == lease_pkg::ST_GEN_REPLACEMENT) |-> !(hit_i || miss_i))
		else begin failures++; $error("strobe during replacement"); end

endmodule

//--- verif/lease_policy_checker.sv
/* lease policy checker
   reference model of leases, table and victim choice, compares DUT outputs */
`include "lease_settings.svh"

module lease_policy_checker (
	input logic                                  clock_i, resetn_i, con_wren_i, llt_wren_i,
	input logic [$clog2(`LEASE_LLT_ENTRIES)+1:0] llt_addr_i,
	input logic [31:0]                           llt_data_i,
	input logic [`LEASE_REF_ADDR_BW-1:0]         llt_search_addr_i,
	input logic [2:0]                            cache_addr_i, addr_o,
	input logic                                  hit_i, miss_i, done_o, swap_o,
	input logic                                  expired_o, expired_multi_o, default_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINES = 8;
	localparam int EBW   = $clog2(`LEASE_LLT_ENTRIES);

	int unsigned errors = 0;
	int unsigned test_errors = 0;   // since the last test line
	int unsigned tests = 0;

	// model state
	logic [`LEASE_VALUE_BW-1:0]    m_lease [LINES];
	logic [`LEASE_VALUE_BW-1:0]    m_default, m_saved;
	logic                          m_followup, m_full, in_reset;
	int                            m_cold, m_rot;
	logic                          t_valid [`LEASE_LLT_ENTRIES];
	logic [`LEASE_REF_ADDR_BW-1:0] t_ref   [`LEASE_LLT_ENTRIES];
	logic [`LEASE_VALUE_BW-1:0]    t_lease0 [`LEASE_LLT_ENTRIES], t_lease1 [`LEASE_LLT_ENTRIES];
	logic [`LEASE_PROB_BW-1:0]     t_prob  [`LEASE_LLT_ENTRIES];

	// expected response
	int         wait_cnt = 0;   // negedges until done_o, 0 when none pending
	logic       e_swap, e_expired, e_multi, e_default, e_random, e_hit_default, hit_seen;
	logic [2:0] e_addr;

	// lease for a reference, lowest matching entry wins, default when none
	function automatic logic [`LEASE_VALUE_BW-1:0] ref_lease(input logic [15:0] sa,
		output logic found);
		found     = 1'b0;
		ref_lease = m_default;
		for (int i = `LEASE_LLT_ENTRIES - 1; i >= 0; i--) begin
			if (t_valid[i] && t_ref[i] == sa) begin
				found     = 1'b1;
				ref_lease = (t_prob[i] >= 256) ? t_lease0[i] : t_lease1[i];   // only 0 or 256 loaded
			end
		end
	endfunction

	// walk from the rotation pointer, -1 when nothing expired
	function automatic int first_expired(output int n_expired);
		first_expired = -1;
		n_expired     = 0;
		for (int k = 0; k < LINES; k++) begin
			if (m_lease[(m_rot + k) % LINES] == 0) begin
				n_expired++;
				if (first_expired < 0)
					first_expired = (m_rot + k) % LINES;
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic count_down();
		for (int i = 0; i < LINES; i++)
			m_lease[i] = (m_lease[i] == 0) ? 0 : m_lease[i] - 1;   // saturate at zero
	endtask

	// one strobe into the model
	// ----------------------------------------------------------------------
	task automatic take_strobe();
		logic [`LEASE_VALUE_BW-1:0] sel;
		logic                       found;
		int                         idx;
		int                         n_exp;
		sel = ref_lease(llt_search_addr_i, found);
		if (hit_i) begin
			hit_seen      = 1'b1;
			e_hit_default = 1'b0;
			if (m_followup) begin
				m_followup            = 1'b0;   // install only, no countdown
				m_lease[cache_addr_i] = m_saved;
			end else begin
				count_down();
				m_lease[cache_addr_i] = sel;
				e_hit_default         = !found;
			end
		end else if (miss_i) begin
			count_down();
			e_default = !found;
			e_swap    = (sel != 0);
			e_expired = 1'b0;
			e_multi   = 1'b0;
			e_random  = 1'b0;
			wait_cnt  = e_swap ? 2 : 1;   // bypass one cycle sooner
			if (e_swap) begin
				m_followup = 1'b1;
				m_saved    = sel;
				if (!m_full) begin
					e_addr = m_cold;   // cold fill in order
					m_cold++;
					m_full = (m_cold == LINES);
				end else begin
					idx = first_expired(n_exp);
					if (idx >= 0) begin
						e_addr    = idx;
						e_expired = 1'b1;
						e_multi   = (n_exp > 1);
						m_rot     = (idx + 1) % LINES;
					end else begin
						e_random = 1'b1;   // victim unknown to the model
					end
				end
			end
		end
	endtask

	task automatic compare_outputs();
		logic exp_done;
		exp_done = 1'b0;
		if (wait_cnt > 0) begin
			wait_cnt--;
			exp_done = (wait_cnt == 0);
		end
		check_value("done_o", done_o, exp_done);
		check_value("swap_o", swap_o, exp_done && e_swap);
		check_value("expired_o", expired_o, exp_done && e_expired);
		check_value("expired_multi_o", expired_multi_o, exp_done && e_multi);
		check_value("default_o", default_o, exp_done ? e_default : (hit_seen && e_hit_default));
		if (exp_done && e_swap && !e_random)
			check_value("addr_o", addr_o, e_addr);
		else if (exp_done && e_swap)
			check_value("addr_o below capacity", addr_o < LINES, 1'b1);
	endtask

	// strobes and writes on the rising edge, outputs on the falling edge
	always begin
		@(posedge clock_i);
		hit_seen = 1'b0;
		in_reset = !resetn_i;
		if (in_reset) begin
			m_lease    = '{default: '0};
			t_valid    = '{default: 1'b0};
			m_default  = '0;
			m_followup = 1'b0;
			m_full     = 1'b0;
			m_cold     = 0;
			m_rot      = 0;
			wait_cnt   = 0;
		end else begin
			take_strobe();
			if (con_wren_i && llt_addr_i == 0)
				m_default = llt_data_i[`LEASE_VALUE_BW-1:0];
			if (llt_wren_i) begin
				case (llt_addr_i[EBW+1:EBW])
					2'd0: begin
						t_ref[llt_addr_i[EBW-1:0]]   = llt_data_i[`LEASE_REF_ADDR_BW-1:0];
						t_valid[llt_addr_i[EBW-1:0]] = 1'b1;
					end
					2'd1: t_lease0[llt_addr_i[EBW-1:0]] = llt_data_i[`LEASE_VALUE_BW-1:0];
					2'd2: t_lease1[llt_addr_i[EBW-1:0]] = llt_data_i[`LEASE_VALUE_BW-1:0];
					default: t_prob[llt_addr_i[EBW-1:0]] = llt_data_i[`LEASE_PROB_BW-1:0];
				endcase
			end
		end
		@(negedge clock_i);
		if (!in_reset)
			compare_outputs();
	end

	task automatic check_reset_state();
		check_value("done_o", done_o, 1'b0);
		check_value("swap_o", swap_o, 1'b0);
		check_value("expired_o", expired_o, 1'b0);
		check_value("expired_multi_o", expired_multi_o, 1'b0);
		check_value("default_o", default_o, 1'b0);
		check_value("addr_o", addr_o, 3'd0);
	endtask

	task automatic end_test(input string name);
		@(posedge clock_i);   // let the last compare land in this test
		tests++;
		$display("test %0d %s: %s, %0d mismatches", tests, name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

endmodule

//--- verif/lease_policy_tb.sv
/* lease policy testbench
   cold fill, bypass, expired and random victims, lease install through hits */
`include "lease_settings.svh"

module lease_policy_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CAP        = 8;
	localparam int EBW        = $clog2(`LEASE_LLT_ENTRIES);
	localparam int CLK_PERIOD = 10;
	localparam int STROBES    = 56;                // hits and misses over all tests
	localparam int WATCHDOG   = STROBES * 4 + 100;  // cycles, margin for reset and writes

	logic                          clock_i = 1'b0;
	logic                          resetn_i, con_wren_i, llt_wren_i, hit_i, miss_i;
	logic [EBW+1:0]                llt_addr_i;
	logic [31:0]                   llt_data_i;
	logic [`LEASE_REF_ADDR_BW-1:0] llt_search_addr_i;
	logic [$clog2(CAP)-1:0]        cache_addr_i, addr_o;
	logic                          done_o, swap_o, expired_o, expired_multi_o, default_o;
	integer                        seed = 87;
	int                            tb_errors = 0;
	int                            total;

	always #(CLK_PERIOD / 2) clock_i = ~clock_i;

	lease_cache_policy_top #(.CACHE_BLOCK_CAPACITY(CAP)) DUT (.*);
	lease_policy_checker u_checker (.*);
	bind lease_policy_controller lease_policy_asserts u_asserts (.*);

	// stimulus tasks, inputs move on the falling edge
	// ----------------------------------------------------------------------
	task automatic write_bus(input logic to_table, input logic [EBW+1:0] a, input logic [31:0] d);
		@(negedge clock_i);
		llt_wren_i = to_table;
		con_wren_i = !to_table;   // config write, address zero is the default lease
		llt_addr_i = a;
		llt_data_i = d;
		@(negedge clock_i);
		llt_wren_i = 1'b0;
		con_wren_i = 1'b0;
	endtask

	task automatic load_entry(input int e, input logic [31:0] ref_addr, l0, l1, prob);
		write_bus(1'b1, {lease_pkg::FIELD_REF_ADDR, EBW'(e)}, ref_addr);
		write_bus(1'b1, {lease_pkg::FIELD_LEASE0, EBW'(e)}, l0);
		write_bus(1'b1, {lease_pkg::FIELD_LEASE1, EBW'(e)}, l1);
		write_bus(1'b1, {lease_pkg::FIELD_PROB, EBW'(e)}, prob);
	endtask

	task automatic do_hit(input logic [15:0] sa, input logic [2:0] line);
		@(negedge clock_i);
		hit_i             = 1'b1;
		llt_search_addr_i = sa;
		cache_addr_i      = line;
		@(negedge clock_i);
		hit_i = 1'b0;
	endtask

	// miss, wait for done_o, then the follow-up hit on the victim
	task automatic do_miss(input logic [15:0] sa);
		int n;
		@(negedge clock_i);
		miss_i            = 1'b1;
		llt_search_addr_i = sa;
		@(negedge clock_i);
		miss_i = 1'b0;
		n      = 0;
		while (!done_o && n < 8) begin
			@(negedge clock_i);
			n++;
		end
		if (!done_o) begin
			$display("no done_o within 8 cycles of the miss on %h", sa);
			tb_errors++;
		end else if (swap_o) begin
			do_hit(sa, addr_o);
		end
	endtask

	// never matches a table entry
	function automatic logic [15:0] rand_addr();
		rand_addr = {4'hA, 12'($random(seed))};
	endfunction

	initial begin
		#(WATCHDOG * CLK_PERIOD);
		$display("watchdog timeout after %0d cycles, tests did not finish", WATCHDOG);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		resetn_i          = 1'b0;
		con_wren_i        = 1'b0;
		llt_wren_i        = 1'b0;
		llt_addr_i        = '0;
		llt_data_i        = '0;
		llt_search_addr_i = '0;
		cache_addr_i      = '0;
		hit_i             = 1'b0;
		miss_i            = 1'b0;
		repeat (4) @(posedge clock_i);
		@(negedge clock_i);
		resetn_i = 1'b1;
		u_checker.check_reset_state();
		write_bus(1'b0, '0, 32'd5);                // default lease 5
		load_entry(0, 32'h0100, 0, 0, 256);        // bypass entry
		load_entry(1, 32'h0200, 12, 3, 256);       // always lease0
		load_entry(2, 32'h0300, 20, 2, 0);         // always lease1
		u_checker.end_test("reset state");

		for (int i = 0; i < CAP; i++)
			do_miss(16'h1000 + 16'(i));
		u_checker.end_test("cold fill");

		do_miss(16'h0100);
		write_bus(1'b0, '0, 32'd0);   // default 0, unknown address bypasses
		do_miss(16'h2000);
		write_bus(1'b0, '0, 32'd5);
		u_checker.end_test("bypass");

		repeat (6) do_miss(rand_addr());
		u_checker.end_test("expired victims");

		do_hit(16'h0200, 3'd0);
		do_hit(16'h0300, 3'd1);
		do_hit(rand_addr(), 3'd2);   // default lease, default_o high
		repeat (4) do_miss(rand_addr());
		u_checker.end_test("lease install");

		for (int i = 0; i < CAP; i++)
			do_hit(16'h0200, 3'(i));   // every line live
		repeat (2) do_miss(rand_addr());
		u_checker.end_test("random victim");

		do_hit(16'h0100, 3'd3);   // installs lease 0 so only line 3 is expired
		do_miss(rand_addr());
		u_checker.end_test("single expiry");

		total = u_checker.errors + tb_errors + DUT.u_controller.u_asserts.failures;
		$display("%0d tests, %0d mismatches, %0d handshake errors, %0d assertion failures",
			u_checker.tests, u_checker.errors, tb_errors, DUT.u_controller.u_asserts.failures);
		if (total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
